/* rtl/arq_rx_defs.svh */
`ifndef ARQ_RX_DEFS_SVH
`define ARQ_RX_DEFS_SVH

// header fields
`define ARQ_MODID_W 8
`define ARQ_CHIPID_W 6
`define ARQ_BSEL_W 8

// payload fields
`define ARQ_MODE_W 4
`define ARQ_ADDR_W 32
`define ARQ_DATA_W 64

// receive buffer holds 2**ARQ_BUF_ADDR_W flits
// packet ids share this width, so ids wrap with the buffer
`define ARQ_BUF_ADDR_W 4

`endif

/* rtl/arq_rx_pkg.sv */
`include "arq_rx_defs.svh"

package arq_rx_pkg;

    // single-flit NoC header, arq bit on top
    typedef struct packed {
        logic                     arq;
        logic [`ARQ_BSEL_W-1:0]   bsel;
        logic [`ARQ_MODID_W-1:0]  src_modid;
        logic [`ARQ_CHIPID_W-1:0] src_chipid;
        logic [`ARQ_MODID_W-1:0]  trg_modid;
        logic [`ARQ_CHIPID_W-1:0] trg_chipid;
    } noc_header_t;

    typedef struct packed {
        logic [`ARQ_MODE_W-1:0] mode;
        logic [`ARQ_ADDR_W-1:0] addr;
        logic [`ARQ_DATA_W-1:0] data;
    } noc_payload_t;

    typedef logic [`ARQ_BUF_ADDR_W-1:0] pkt_id_t;

    // one buffered packet with its receive number
    typedef struct packed {
        noc_header_t  header;
        noc_payload_t payload;
        pkt_id_t      packet_id;
    } rx_entry_t;

    // mode carried by every ACK and NACK flit
    localparam logic [`ARQ_MODE_W-1:0] MODE_ARQ_ACK = 4'hF;

    // receive controller states
    typedef enum logic [2:0] {
        IDLE,
        FORWARD,
        DROP,
        ACK,
        NACK
    } rx_state_t;

endpackage

/* rtl/flit_ingress.sv */
module flit_ingress (
    input  logic                     clk_i,
    input  logic                     reset_q_i,

    input  logic                     noc_wrreq_i,
    input  arq_rx_pkg::noc_header_t  noc_header_i,
    input  arq_rx_pkg::noc_payload_t noc_payload_i,
    output logic                     noc_stall_o,

    output logic                     push_o,
    output arq_rx_pkg::rx_entry_t    entry_o,
    input  logic                     full_i,

    output arq_rx_pkg::pkt_id_t      next_id_o,
    output logic [31:0]              rx_count_o
);
    import arq_rx_pkg::*;

    // counts accepted flits, low bits number the packets
    logic [31:0] rx_count_q;
    pkt_id_t     cur_id;

    assign cur_id = rx_count_q[$bits(pkt_id_t)-1:0];

    // a flit is taken whenever the buffer has room
    assign noc_stall_o = full_i;
    assign push_o      = noc_wrreq_i && !full_i;

    assign entry_o = '{header: noc_header_i, payload: noc_payload_i, packet_id: cur_id};

    always_ff @(posedge clk_i or negedge reset_q_i) begin
        if (!reset_q_i) begin
            rx_count_q <= 32'h0;
        end else if (push_o) begin
            rx_count_q <= rx_count_q + 32'd1;
        end
    end

    // id the next accepted flit will get
    assign next_id_o  = cur_id;
    assign rx_count_o = rx_count_q;

endmodule

/* rtl/flit_fifo.sv */
module flit_fifo #(
    parameter type         entry_t = logic [7:0],
    parameter int unsigned ADDR_W  = 4
) (
    input  logic   clk_i,
    input  logic   reset_q_i,

    input  logic   push_i,
    input  entry_t wdata_i,
    output logic   full_o,

    input  logic   pop_i,
    output entry_t rdata_o,
    output logic   empty_o
);

    localparam int unsigned DEPTH = 1 << ADDR_W;

    entry_t mem [DEPTH];

    // extra top bit tells a full buffer from an empty one
    logic [ADDR_W:0] wr_ptr_q;
    logic [ADDR_W:0] rd_ptr_q;
    logic            do_push;
    logic            do_pop;

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                     (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);

    // requests against a full or empty buffer are ignored
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q[ADDR_W-1:0]] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge reset_q_i) begin
        if (!reset_q_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // head is read straight from the array
    assign rdata_o = mem[rd_ptr_q[ADDR_W-1:0]];

endmodule

/* rtl/arq_rx_ctrl.sv */
`include "arq_rx_defs.svh"

module arq_rx_ctrl (
    input  logic                     clk_i,
    input  logic                     reset_q_i,

    input  logic                     empty_i,
    input  arq_rx_pkg::rx_entry_t    head_i,
    output logic                     pop_o,
    input  arq_rx_pkg::pkt_id_t      next_id_i,

    output logic                     mod_wrreq_o,
    output arq_rx_pkg::noc_header_t  mod_header_o,
    output arq_rx_pkg::noc_payload_t mod_payload_o,
    input  logic                     mod_stall_i,

    output logic                     ack_wrreq_o,
    output arq_rx_pkg::noc_header_t  ack_header_o,
    output arq_rx_pkg::noc_payload_t ack_payload_o,
    input  logic                     ack_stall_i,

    input  logic [31:0]              timeout_i,
    output logic [31:0]              rx_drop_o
);
    import arq_rx_pkg::*;

    rx_state_t   state_q;
    rx_state_t   state_d;
    logic [31:0] stall_cnt_q;
    logic [31:0] stall_cnt_d;
    logic [31:0] drop_cnt_q;
    logic [31:0] drop_cnt_d;
    pkt_id_t     drop_mark_q;
    pkt_id_t     drop_mark_d;
    logic        latch;
    logic        ack_flag;

    // fields of the packet the next ACK/NACK answers
    logic [`ARQ_MODID_W-1:0]  src_modid_q;
    logic [`ARQ_CHIPID_W-1:0] src_chipid_q;
    logic [`ARQ_MODID_W-1:0]  trg_modid_q;
    logic [`ARQ_CHIPID_W-1:0] trg_chipid_q;
    logic [`ARQ_ADDR_W-1:0]   addr_q;
    logic [`ARQ_MODE_W-1:0]   mode_q;

    always_comb begin
        state_d     = state_q;
        stall_cnt_d = 32'h0;
        drop_cnt_d  = drop_cnt_q;
        drop_mark_d = drop_mark_q;
        pop_o       = 1'b0;
        mod_wrreq_o = 1'b0;
        latch       = 1'b0;

        case (state_q)
            IDLE: begin
                if (!empty_i) begin
                    latch   = 1'b1;
                    state_d = FORWARD;
                end
            end

            FORWARD: begin
                if (!empty_i) begin
                    mod_wrreq_o = 1'b1;
                    if (!mod_stall_i) begin
                        pop_o   = 1'b1;
                        state_d = head_i.header.arq ? ACK : IDLE;
                    end else if (head_i.header.arq) begin
                        // only ARQ packets can time out
                        stall_cnt_d = stall_cnt_q + 32'd1;
                        if (stall_cnt_q > timeout_i) begin
                            // everything older than the next id gets dropped
                            drop_mark_d = next_id_i;
                            state_d     = DROP;
                        end
                    end
                end
            end

            DROP: begin
                if (!empty_i) begin
                    pop_o      = 1'b1;
                    drop_cnt_d = drop_cnt_q + 32'd1;
                    state_d    = NACK;
                end
            end

            ACK: begin
                if (!ack_stall_i) begin
                    state_d = IDLE;
                end
            end

            NACK: begin
                if (!ack_stall_i) begin
                    if (empty_i || (head_i.packet_id == drop_mark_q)) begin
                        state_d = IDLE;
                    end else begin
                        latch   = 1'b1;
                        state_d = DROP;
                    end
                end
            end

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge reset_q_i) begin
        if (!reset_q_i) begin
            state_q     <= IDLE;
            stall_cnt_q <= 32'h0;
            drop_cnt_q  <= 32'h0;
            drop_mark_q <= '0;
        end else begin
            state_q     <= state_d;
            stall_cnt_q <= stall_cnt_d;
            drop_cnt_q  <= drop_cnt_d;
            drop_mark_q <= drop_mark_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (latch) begin
            src_modid_q  <= head_i.header.src_modid;
            src_chipid_q <= head_i.header.src_chipid;
            trg_modid_q  <= head_i.header.trg_modid;
            trg_chipid_q <= head_i.header.trg_chipid;
            addr_q       <= head_i.payload.addr;
            mode_q       <= head_i.payload.mode;
        end
    end

    // the module sees the buffer head unchanged
    assign mod_header_o  = head_i.header;
    assign mod_payload_o = head_i.payload;

    assign ack_wrreq_o = (state_q == ACK) || (state_q == NACK);
    assign ack_flag    = (state_q == ACK);

    // reply goes back to the sender, so src and trg swap
    assign ack_header_o = '{
        arq:        1'b0,
        bsel:       {`ARQ_BSEL_W{1'b1}},
        src_modid:  trg_modid_q,
        src_chipid: trg_chipid_q,
        trg_modid:  src_modid_q,
        trg_chipid: src_chipid_q
    };

    assign ack_payload_o = '{
        mode: MODE_ARQ_ACK,
        addr: addr_q,
        data: {{(`ARQ_DATA_W - `ARQ_MODE_W - 1){1'b0}}, ack_flag, mode_q}
    };

    assign rx_drop_o = drop_cnt_q;

endmodule

/* rtl/noc_arq_rx.sv */
`include "arq_rx_defs.svh"

module noc_arq_rx (
    input  logic                     clk_i,
    input  logic                     reset_q_i,

    // from the NoC
    input  logic                     noc_wrreq_i,
    input  arq_rx_pkg::noc_header_t  noc_header_i,
    input  arq_rx_pkg::noc_payload_t noc_payload_i,
    output logic                     noc_stall_o,

    // to the local module
    output logic                     mod_wrreq_o,
    output arq_rx_pkg::noc_header_t  mod_header_o,
    output arq_rx_pkg::noc_payload_t mod_payload_o,
    input  logic                     mod_stall_i,

    // ACK/NACK back into the NoC
    output logic                     ack_wrreq_o,
    output arq_rx_pkg::noc_header_t  ack_header_o,
    output arq_rx_pkg::noc_payload_t ack_payload_o,
    input  logic                     ack_stall_i,

    input  logic [31:0]              arq_timeout_rx_cycles_i,
    output logic [31:0]              noc_rx_count_o,
    output logic [31:0]              noc_rx_drop_o
);
    import arq_rx_pkg::*;

    logic      push;
    logic      full;
    logic      pop;
    logic      empty;
    rx_entry_t wr_entry;
    rx_entry_t head;
    pkt_id_t   next_id;

    flit_ingress u_ingress (
        .clk_i         (clk_i),
        .reset_q_i     (reset_q_i),
        .noc_wrreq_i   (noc_wrreq_i),
        .noc_header_i  (noc_header_i),
        .noc_payload_i (noc_payload_i),
        .noc_stall_o   (noc_stall_o),
        .push_o        (push),
        .entry_o       (wr_entry),
        .full_i        (full),
        .next_id_o     (next_id),
        .rx_count_o    (noc_rx_count_o)
    );

    flit_fifo #(
        .entry_t (rx_entry_t),
        .ADDR_W  (`ARQ_BUF_ADDR_W)
    ) u_fifo (
        .clk_i     (clk_i),
        .reset_q_i (reset_q_i),
        .push_i    (push),
        .wdata_i   (wr_entry),
        .full_o    (full),
        .pop_i     (pop),
        .rdata_o   (head),
        .empty_o   (empty)
    );

    arq_rx_ctrl u_ctrl (
        .clk_i         (clk_i),
        .reset_q_i     (reset_q_i),
        .empty_i       (empty),
        .head_i        (head),
        .pop_o         (pop),
        .next_id_i     (next_id),
        .mod_wrreq_o   (mod_wrreq_o),
        .mod_header_o  (mod_header_o),
        .mod_payload_o (mod_payload_o),
        .mod_stall_i   (mod_stall_i),
        .ack_wrreq_o   (ack_wrreq_o),
        .ack_header_o  (ack_header_o),
        .ack_payload_o (ack_payload_o),
        .ack_stall_i   (ack_stall_i),
        .timeout_i     (arq_timeout_rx_cycles_i),
        .rx_drop_o     (noc_rx_drop_o)
    );

endmodule

/* testbench/tb_noc_arq_rx.sv */
`include "arq_rx_defs.svh"

module tb_noc_arq_rx;
    import arq_rx_pkg::*;

    typedef struct packed {
        noc_header_t  header;
        noc_payload_t payload;
    } flit_t;

    logic         clk_i = 1'b0;
    logic         reset_q_i;
    logic         noc_wrreq_i;
    noc_header_t  noc_header_i;
    noc_payload_t noc_payload_i;
    logic         noc_stall_o;
    logic         mod_wrreq_o;
    noc_header_t  mod_header_o;
    noc_payload_t mod_payload_o;
    logic         mod_stall_i;
    logic         ack_wrreq_o;
    noc_header_t  ack_header_o;
    noc_payload_t ack_payload_o;
    logic         ack_stall_i;
    logic [31:0]  arq_timeout_rx_cycles_i;
    logic [31:0]  noc_rx_count_o;
    logic [31:0]  noc_rx_drop_o;

    // expected flits per output stream and the front of each queue
    flit_t       mod_q[$];
    flit_t       ack_q[$];
    flit_t       mod_exp;
    flit_t       ack_exp;
    int unsigned mod_pending;
    int unsigned ack_pending;
    logic        mod_fire_q;
    logic        ack_fire_q;
    int unsigned accepted;

    always #5 clk_i = ~clk_i;

    noc_arq_rx dut (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        abort_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_count(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else report_value(name, 128'(got), 128'(exp));
    endtask

    function automatic void refresh_fronts();
        mod_pending = mod_q.size();
        ack_pending = ack_q.size();
        mod_exp     = (mod_pending != 0) ? mod_q[0] : '0;
        ack_exp     = (ack_pending != 0) ? ack_q[0] : '0;
    endfunction

    function automatic flit_t random_flit(input logic arq);
        logic [255:0] r;
        flit_t        f;
        r = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
        f = r[$bits(flit_t)-1:0];
        f.header.arq = arq;
        return f;
    endfunction

    // reply flit goes back to the sender with ids swapped
    function automatic flit_t reply_of(input flit_t p, input logic ack);
        flit_t r;
        r.header.arq        = 1'b0;
        r.header.bsel       = '1;
        r.header.src_modid  = p.header.trg_modid;
        r.header.src_chipid = p.header.trg_chipid;
        r.header.trg_modid  = p.header.src_modid;
        r.header.trg_chipid = p.header.src_chipid;
        r.payload.mode      = MODE_ARQ_ACK;
        r.payload.addr      = p.payload.addr;
        r.payload.data      = '0;
        r.payload.data[`ARQ_MODE_W]     = ack;
        r.payload.data[`ARQ_MODE_W-1:0] = p.payload.mode;
        return r;
    endfunction

    // called just after a falling edge
    // returns one falling edge after the flit is taken
    task automatic send_flit(input flit_t f, input logic forwarded);
        int waited;
        waited        = 0;
        noc_wrreq_i   = 1'b1;
        noc_header_i  = f.header;
        noc_payload_i = f.payload;
        while (noc_stall_o) begin
            waited++;
            if (waited > 100) abort_run("timeout: the NoC input never accepted a flit");
            @(negedge clk_i);
        end
        accepted++;
        if (forwarded) mod_q.push_back(f);
        if (!forwarded || f.header.arq) ack_q.push_back(reply_of(f, forwarded));
        refresh_fronts();
        @(negedge clk_i);
        noc_wrreq_i = 1'b0;
    endtask

    task automatic drain(input int limit);
        int waited;
        waited = 0;
        while (mod_q.size() != 0 || ack_q.size() != 0) begin
            waited++;
            if (waited > limit) abort_run("timeout: expected packets or replies never came out");
            @(negedge clk_i);
        end
    endtask

    always @(posedge clk_i) begin
        mod_fire_q <= mod_wrreq_o && !mod_stall_i;
        ack_fire_q <= ack_wrreq_o && !ack_stall_i;
    end

    always @(negedge clk_i) begin
        if (mod_fire_q && mod_q.size() != 0) void'(mod_q.pop_front());
        if (ack_fire_q && ack_q.size() != 0) void'(ack_q.pop_front());
        refresh_fronts();
    end

    assert property (@(posedge clk_i) disable iff (!reset_q_i)
        mod_wrreq_o && !mod_stall_i |-> mod_pending != 0)
        else abort_run("a packet was forwarded that nobody sent or that should be dropped");
    assert property (@(posedge clk_i) disable iff (!reset_q_i)
        mod_wrreq_o && !mod_stall_i |-> mod_header_o == mod_exp.header)
        else report_value("mod_header_o", 128'($sampled(mod_header_o)), 128'(mod_exp.header));
    assert property (@(posedge clk_i) disable iff (!reset_q_i)
        mod_wrreq_o && !mod_stall_i |-> mod_payload_o == mod_exp.payload)
        else report_value("mod_payload_o", 128'($sampled(mod_payload_o)),
                          128'(mod_exp.payload));
    assert property (@(posedge clk_i) disable iff (!reset_q_i)
        ack_wrreq_o && !ack_stall_i |-> ack_pending != 0)
        else abort_run("an ACK or NACK was sent that was not expected");
    assert property (@(posedge clk_i) disable iff (!reset_q_i)
        ack_wrreq_o && !ack_stall_i |-> ack_header_o == ack_exp.header)
        else report_value("ack_header_o", 128'($sampled(ack_header_o)), 128'(ack_exp.header));
    assert property (@(posedge clk_i) disable iff (!reset_q_i)
        ack_wrreq_o && !ack_stall_i |-> ack_payload_o == ack_exp.payload)
        else report_value("ack_payload_o", 128'($sampled(ack_payload_o)),
                          128'(ack_exp.payload));
    // a stalled reply must hold its request and content
    assert property (@(posedge clk_i) disable iff (!reset_q_i)
        ack_wrreq_o && ack_stall_i |=>
            ack_wrreq_o && $stable(ack_header_o) && $stable(ack_payload_o))
        else abort_run("the ACK/NACK flit changed or vanished while stalled");

    initial begin
        int   waited;
        void'($urandom(32'h286d51e2));
        reset_q_i               = 1'b0;
        noc_wrreq_i             = 1'b0;
        noc_header_i            = '0;
        noc_payload_i           = '0;
        mod_stall_i             = 1'b0;
        ack_stall_i             = 1'b0;
        arq_timeout_rx_cycles_i = 32'd1000;
        accepted                = 0;
        waited                  = 0;
        refresh_fronts();
        repeat (3) @(negedge clk_i);
        reset_q_i = 1'b1;
        assert (!mod_wrreq_o && !ack_wrreq_o && !noc_stall_o)
            else abort_run("a request or stall output is high right after reset");
        check_count("noc_rx_count_o", noc_rx_count_o, 32'd0);
        check_count("noc_rx_drop_o", noc_rx_drop_o, 32'd0);

        // plain packets pass straight through
        repeat (20) send_flit(random_flit(1'b0), 1'b1);
        drain(200);
        check_count("noc_rx_count_o", noc_rx_count_o, accepted);

        // first ACK is held back for a few cycles
        ack_stall_i = 1'b1;
        send_flit(random_flit(1'b1), 1'b1);
        while (!ack_wrreq_o) begin
            waited++;
            if (waited > 50) abort_run("timeout: no ACK request after an ARQ packet");
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);
        ack_stall_i = 1'b0;
        repeat (6) send_flit(random_flit(1'b1), 1'b1);
        drain(200);

        // fill all 16 entries, then offer one more
        mod_stall_i = 1'b1;
        repeat (16) send_flit(random_flit(1'b0), 1'b1);
        noc_wrreq_i = 1'b1;
        {noc_header_i, noc_payload_i} = random_flit(1'b0);
        repeat (5) begin
            assert (noc_stall_o) else abort_run("noc_stall_o is low with a full buffer");
            @(negedge clk_i);
        end
        noc_wrreq_i = 1'b0;
        check_count("noc_rx_count_o", noc_rx_count_o, accepted);
        mod_stall_i = 1'b0;
        drain(300);

        // stalled ARQ head times out and takes everything buffered with it
        arq_timeout_rx_cycles_i = 32'd8;
        mod_stall_i = 1'b1;
        ack_stall_i = 1'b1;
        send_flit(random_flit(1'b1), 1'b0);
        repeat (3) send_flit(random_flit(1'($urandom)), 1'b0);
        waited = 0;
        while (!ack_wrreq_o) begin
            waited++;
            if (waited > 50) abort_run("timeout: the stalled ARQ packet never timed out");
            @(negedge clk_i);
        end
        // packets arriving after the timeout lie past the drop mark and survive
        mod_stall_i = 1'b0;
        repeat (2) send_flit(random_flit(1'($urandom)), 1'b1);
        ack_stall_i = 1'b0;
        drain(300);
        check_count("noc_rx_drop_o", noc_rx_drop_o, 32'd4);
        arq_timeout_rx_cycles_i = 32'd1000;
        repeat (5) send_flit(random_flit(1'($urandom)), 1'b1);
        drain(200);
        check_count("noc_rx_count_o", noc_rx_count_o, accepted);
        check_count("noc_rx_drop_o", noc_rx_drop_o, 32'd4);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
rtl/arq_rx_pkg.sv
rtl/flit_ingress.sv
rtl/flit_fifo.sv
rtl/arq_rx_ctrl.sv
rtl/noc_arq_rx.sv
testbench/tb_noc_arq_rx.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_noc_arq_rx -f project.f

# the simulator exits non-zero on failure, so the output is searched instead
out=$(./obj_dir/Vtb_noc_arq_rx 2>&1) || true
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi
